// File: hw/ralu_pkg.sv
// remote ALU shared definitions
// widths, wire depth, decoded bus layout and opcode encodings
`default_nettype none

package ralu_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------

  // operand and result width
  localparam int DATA_W = 16;
  // opcode width on the command input
  localparam int OP_W = 3;
  // decoded ALU function width
  localparam int ALU_OP_W = 3;
  // result counter width, wraps around
  localparam int CNT_W = 16;
  // register stages on the long wire between decode and execute
  localparam int WIRE_STAGES = 3;

  // ------------------------------------------------------------
  // decoded bus layout, lsb first
  // ------------------------------------------------------------

  // operand b sits at the bottom
  localparam int DEC_B_LSB = 0;
  localparam int DEC_A_LSB = DEC_B_LSB + DATA_W;
  // one bit flags an illegal command
  localparam int DEC_ILL_BIT = DEC_A_LSB + DATA_W;
  // ALU function on top
  localparam int DEC_OP_LSB = DEC_ILL_BIT + 1;
  // 3 + 1 + 2 x 16 = 36 bits across the wire
  localparam int DEC_W = DEC_OP_LSB + ALU_OP_W;

  // ------------------------------------------------------------
  // opcodes
  // ------------------------------------------------------------

  // command opcodes as driven from outside
  // codes 6 and 7 are illegal
  typedef enum logic [OP_W-1:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    XOR = 3'd3,
    ACC = 3'd4,
    CLR = 3'd5
  } cmd_op_e;

  // decoded ALU function, NOP marks an illegal command
  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_XOR = 3'd3,
    ALU_ACC = 3'd4,
    ALU_CLR = 3'd5,
    ALU_NOP = 3'd7
  } alu_op_e;

endpackage

`default_nettype wire

// File: hw/ralu_cmd_decode.sv
// remote ALU command decode
// checks the opcode and registers the decoded fields behind a delayed valid_next
`timescale 1ns/1ps
`default_nettype none

module ralu_cmd_decode (
  input  logic                        clk,
  input  logic                        rst_n,
  // command arrives one cycle after this strobe
  input  logic                        cmd_valid_next,
  input  logic [ralu_pkg::OP_W-1:0]   cmd_op,
  input  logic [ralu_pkg::DATA_W-1:0] cmd_a,
  input  logic [ralu_pkg::DATA_W-1:0] cmd_b,
  // high one cycle before dec_bus holds the command
  output logic                        dec_valid_next,
  output logic [ralu_pkg::DEC_W-1:0]  dec_bus
);

  import ralu_pkg::*;

  // ------------------------------------------------------------
  // opcode decode
  // ------------------------------------------------------------

  alu_op_e alu_op;
  logic    illegal;

  always_comb begin
    // legal unless the default arm says otherwise
    illegal = 1'b0;
    case (cmd_op_e'(cmd_op))
      ADD: alu_op = ALU_ADD;
      SUB: alu_op = ALU_SUB;
      AND: alu_op = ALU_AND;
      XOR: alu_op = ALU_XOR;
      ACC: alu_op = ALU_ACC;
      CLR: alu_op = ALU_CLR;
      default: begin
        // codes 6 and 7 become a NOP that reports an error
        alu_op  = ALU_NOP;
        illegal = 1'b1;
      end
    endcase
  end

  // ------------------------------------------------------------
  // strobe and field registers
  // ------------------------------------------------------------

  // strobe moves one cycle, now lines up with the command data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid_next <= 1'b0;
    end else begin
      dec_valid_next <= cmd_valid_next;
    end
  end

  // fields load only in the data cycle
  // so the wide register does not toggle on idle cycles
  always_ff @(posedge clk) begin
    if (dec_valid_next) begin
      dec_bus[DEC_OP_LSB +: ALU_OP_W] <= alu_op;
      dec_bus[DEC_ILL_BIT]            <= illegal;
      dec_bus[DEC_A_LSB +: DATA_W]    <= cmd_a;
      dec_bus[DEC_B_LSB +: DATA_W]    <= cmd_b;
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // the sender must hold a clean opcode one cycle after its strobe
  cmd_op_known_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    dec_valid_next |-> !$isunknown(cmd_op)
  );

endmodule

`default_nettype wire

// File: hw/ralu_delay_valid_next.sv
// valid_next delay line for the long wire
// datapath stages load only when the matching strobe says data arrives
`timescale 1ns/1ps
`default_nettype none

module ralu_delay_valid_next #(
  // bus width of at least 1 bit
  parameter int Width     = 1,
  // register stages where 0 gives a pass-through
  parameter int NumStages = 0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid_next,
  input  logic [Width-1:0] in_data,
  output logic             out_valid_next,
  output logic [Width-1:0] out_data
);

  // ------------------------------------------------------------
  // stage registers
  // ------------------------------------------------------------

  // index 0 is the input side
  logic             stage_vn   [NumStages+1];
  logic [Width-1:0] stage_data [NumStages+1];

  if (Width < 1 || NumStages < 0) begin : gen_bad_params
    $error("ralu_delay_valid_next needs Width >= 1 and NumStages >= 0");
  end

  assign stage_vn[0]   = in_valid_next;
  assign stage_data[0] = in_data;

  for (genvar i = 1; i <= NumStages; i++) begin : gen_stages
    // strobe stages carry reset
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        stage_vn[i] <= 1'b0;
      end else begin
        stage_vn[i] <= stage_vn[i-1];
      end
    end

    // stage_vn[i] lines up with the data of stage i-1
    // hence it is the load enable here
    always_ff @(posedge clk) begin
      if (stage_vn[i]) begin
        stage_data[i] <= stage_data[i-1];
      end
    end
  end

  assign out_valid_next = stage_vn[NumStages];
  assign out_data       = stage_data[NumStages];

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  if (NumStages > 0) begin : gen_delay_chk
    // strobe arrives exactly NumStages cycles late
    valid_next_delay_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      ##NumStages out_valid_next == $past(in_valid_next, NumStages)
    );
    // data follows its own strobe by one cycle as on the input
    data_delay_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      in_valid_next |-> ##NumStages out_valid_next
        ##1 (out_data == $past(in_data, NumStages))
    );
  end

endmodule

`default_nettype wire

// File: hw/ralu_execute.sv
// remote ALU execute stage
// runs the decoded function, keeps the accumulator and registers the result
`timescale 1ns/1ps
`default_nettype none

module ralu_execute (
  input  logic                        clk,
  input  logic                        rst_n,
  // bus holds a command one cycle after this strobe
  input  logic                        in_valid_next,
  input  logic [ralu_pkg::DEC_W-1:0]  in_bus,
  // one-cycle result pulse
  output logic                        ex_valid,
  output logic [ralu_pkg::DATA_W-1:0] ex_data,
  output logic                        ex_err
);

  import ralu_pkg::*;

  // ------------------------------------------------------------
  // bus unpack
  // ------------------------------------------------------------

  // high while in_bus carries a command
  logic              bus_valid;
  alu_op_e           op;
  logic              illegal;
  logic [DATA_W-1:0] opa;
  logic [DATA_W-1:0] opb;

  assign op      = alu_op_e'(in_bus[DEC_OP_LSB +: ALU_OP_W]);
  assign illegal = in_bus[DEC_ILL_BIT];
  assign opa     = in_bus[DEC_A_LSB +: DATA_W];
  assign opb     = in_bus[DEC_B_LSB +: DATA_W];

  // ------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------

  logic [DATA_W-1:0] acc;
  logic [DATA_W-1:0] acc_nxt;
  logic [DATA_W-1:0] data_nxt;
  logic              err_nxt;

  always_comb begin
    // defaults give the NOP result, 0 with accumulator held
    acc_nxt  = acc;
    data_nxt = '0;
    err_nxt  = 1'b0;
    if (illegal) begin
      err_nxt = 1'b1;
    end else begin
      case (op)
        // plain 16 bit wrap-around
        ALU_ADD: data_nxt = opa + opb;
        ALU_SUB: data_nxt = opa - opb;
        ALU_AND: data_nxt = opa & opb;
        ALU_XOR: data_nxt = opa ^ opb;
        ALU_ACC: begin
          // returns the updated sum
          acc_nxt  = acc + opa;
          data_nxt = acc + opa;
        end
        ALU_CLR: begin
          acc_nxt  = '0;
          data_nxt = '0;
        end
        // NOP or a code decode never emits
        default: err_nxt = 1'b1;
      endcase
    end
  end

  // ------------------------------------------------------------
  // registers
  // ------------------------------------------------------------

  // accumulator moves only on a real command
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_valid <= 1'b0;
      ex_valid  <= 1'b0;
      acc       <= '0;
    end else begin
      bus_valid <= in_valid_next;
      ex_valid  <= bus_valid;
      if (bus_valid) begin
        acc <= acc_nxt;
      end
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    if (bus_valid) begin
      ex_data <= data_nxt;
      ex_err  <= err_nxt;
    end
  end

  // a lone command upstream gives a single-cycle pulse here
  ex_valid_single_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (ex_valid && !$past(in_valid_next)) |=> !ex_valid
  );

endmodule

`default_nettype wire

// File: hw/ralu_result.sv
// remote ALU result stage
// output register, sticky error flag and wrap-around result counter
`timescale 1ns/1ps
`default_nettype none

module ralu_result (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        ex_valid,
  input  logic                        ex_err,
  input  logic [ralu_pkg::DATA_W-1:0] ex_data,
  output logic                        res_valid,
  output logic                        res_err,
  output logic                        err_seen,
  output logic [ralu_pkg::DATA_W-1:0] res_data,
  output logic [ralu_pkg::CNT_W-1:0]  res_count
);

  import ralu_pkg::*;

  // ------------------------------------------------------------
  // control state
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
      err_seen  <= 1'b0;
      res_count <= '0;
    end else begin
      // one pulse per result
      res_valid <= ex_valid;
      // sticky, only reset clears it
      if (ex_valid && ex_err) begin
        err_seen <= 1'b1;
      end
      // count wraps at 2**CNT_W
      if (ex_valid) begin
        res_count <= res_count + CNT_W'(1);
      end
    end
  end

  // ------------------------------------------------------------
  // output payload
  // ------------------------------------------------------------

  // held between results
  always_ff @(posedge clk) begin
    if (ex_valid) begin
      res_data <= ex_data;
      res_err  <= ex_err;
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------

  // counter steps by one with each pulse and holds otherwise
  count_step_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    res_count == CNT_W'($past(res_count) + CNT_W'(res_valid))
  );

endmodule

`default_nettype wire

// File: hw/ralu_top.sv
// remote ALU top level
// decode, long wire delay, execute and result in one fixed-latency pipe
`timescale 1ns/1ps
`default_nettype none

module ralu_top (
  input  logic                        clk,
  input  logic                        rst_n,
  // command side, data one cycle after the strobe
  input  logic                        cmd_valid_next,
  input  logic [ralu_pkg::OP_W-1:0]   cmd_op,
  input  logic [ralu_pkg::DATA_W-1:0] cmd_a,
  input  logic [ralu_pkg::DATA_W-1:0] cmd_b,
  // result side
  output logic                        res_valid,
  output logic [ralu_pkg::DATA_W-1:0] res_data,
  output logic                        res_err,
  output logic                        err_seen,
  output logic [ralu_pkg::CNT_W-1:0]  res_count
);

  import ralu_pkg::*;

  // ------------------------------------------------------------
  // interconnect
  // ------------------------------------------------------------

  // decode out
  logic              dec_valid_next;
  logic [DEC_W-1:0]  dec_bus;
  // far end of the wire
  logic              wire_valid_next;
  logic [DEC_W-1:0]  wire_bus;
  // execute out
  logic              ex_valid;
  logic [DATA_W-1:0] ex_data;
  logic              ex_err;

  ralu_cmd_decode ralu_cmd_decode_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_valid_next (cmd_valid_next),
    .cmd_op         (cmd_op),
    .cmd_a          (cmd_a),
    .cmd_b          (cmd_b),
    .dec_valid_next (dec_valid_next),
    .dec_bus        (dec_bus)
  );

  // long wire, WIRE_STAGES cycles
  ralu_delay_valid_next #(
    .Width     (DEC_W),
    .NumStages (WIRE_STAGES)
  ) ralu_wire_delay_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid_next  (dec_valid_next),
    .in_data        (dec_bus),
    .out_valid_next (wire_valid_next),
    .out_data       (wire_bus)
  );

  ralu_execute ralu_execute_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid_next (wire_valid_next),
    .in_bus        (wire_bus),
    .ex_valid      (ex_valid),
    .ex_data       (ex_data),
    .ex_err        (ex_err)
  );

  ralu_result ralu_result_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex_valid  (ex_valid),
    .ex_err    (ex_err),
    .ex_data   (ex_data),
    .res_valid (res_valid),
    .res_err   (res_err),
    .err_seen  (err_seen),
    .res_data  (res_data),
    .res_count (res_count)
  );

endmodule

`default_nettype wire

// File: bench/ralu_tb.sv
// remote ALU testbench
// directed tests for the fixed-latency pipe, the accumulator and the error flags
`timescale 1ns/1ps
`default_nettype none

module ralu_tb;

  import ralu_pkg::*;

  // command data cycle to res_valid
  localparam int LATENCY     = WIRE_STAGES + 3;
  localparam int TIMEOUT_CYC = 4 * LATENCY + 20;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              cmd_valid_next;
  logic [OP_W-1:0]   cmd_op;
  logic [DATA_W-1:0] cmd_a;
  logic [DATA_W-1:0] cmd_b;
  logic              res_valid;
  logic [DATA_W-1:0] res_data;
  logic              res_err;
  logic              err_seen;
  logic [CNT_W-1:0]  res_count;

  // cycle number, steps on every rising edge
  int                cyc = 0;
  int                errors = 0;
  int                checks = 0;
  int                test_err_base = 0;
  logic [31:0]       lcg_state;
  // accumulator as the command rules predict it
  logic [DATA_W-1:0] model_acc;
  // commands sent since reset, wraps like the counter
  logic [CNT_W-1:0]  exp_count;

  // commands waiting for the next burst
  logic [OP_W-1:0]   pend_op[$];
  logic [DATA_W-1:0] pend_a[$];
  logic [DATA_W-1:0] pend_b[$];
  // expected results, in command order
  logic [DATA_W-1:0] exp_data[$];
  logic              exp_err[$];
  int                exp_cyc[$];
  // results seen on the output
  logic [DATA_W-1:0] got_data[$];
  logic              got_err[$];
  int                got_cyc[$];

  ralu_top ralu_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_valid_next (cmd_valid_next),
    .cmd_op         (cmd_op),
    .cmd_a          (cmd_a),
    .cmd_b          (cmd_b),
    .res_valid      (res_valid),
    .res_data       (res_data),
    .res_err        (res_err),
    .err_seen       (err_seen),
    .res_count      (res_count)
  );

  // 4 ns period
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && res_valid) begin
      got_data.push_back(res_data);
      got_err.push_back(res_err);
      got_cyc.push_back(cyc);
    end
  end

  // ------------------------------------------------------------
  // random numbers and compare tasks
  // ------------------------------------------------------------

  function automatic logic [DATA_W-1:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // upper bits of an LCG are the better ones
    return lcg_state[31:32-DATA_W];
  endfunction

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0d ns: %s is 0x%04h, expected 0x%04h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0d ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                             input logic [CNT_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERROR at %0d ns: %s is cycle %0d, expected cycle %0d", $time, name, got, exp);
    end
  endtask

  // ------------------------------------------------------------
  // command helpers
  // ------------------------------------------------------------

  // result of one command under the opcode rules
  task automatic predict(input logic [OP_W-1:0] op, input logic [DATA_W-1:0] a,
                         input logic [DATA_W-1:0] b, output logic [DATA_W-1:0] data,
                         output logic err);
    data = '0;
    err  = 1'b0;
    case (op)
      ADD: data = a + b;
      SUB: data = a - b;
      AND: data = a & b;
      XOR: data = a ^ b;
      ACC: begin
        model_acc = model_acc + a;
        data      = model_acc;
      end
      CLR: model_acc = '0;
      // codes 6 and 7 leave the accumulator untouched
      default: err = 1'b1;
    endcase
  endtask

  task automatic expect_cmd(input logic [OP_W-1:0] op, input logic [DATA_W-1:0] a,
                            input logic [DATA_W-1:0] b, input logic [DATA_W-1:0] data,
                            input logic err);
    pend_op.push_back(op);
    pend_a.push_back(a);
    pend_b.push_back(b);
    exp_data.push_back(data);
    exp_err.push_back(err);
  endtask

  task automatic queue_cmd(input logic [OP_W-1:0] op, input logic [DATA_W-1:0] a,
                           input logic [DATA_W-1:0] b);
    logic [DATA_W-1:0] data;
    logic              err;
    predict(op, a, b, data, err);
    expect_cmd(op, a, b, data, err);
  endtask

  // strobe of command t+1 goes out with the data of command t
  task automatic send_burst();
    int n;
    int t;
    n = pend_op.size();
    for (t = 0; t <= n; t++) begin
      @(posedge clk);
      #1;
      cmd_valid_next = (t < n);
      if (t > 0) begin
        cmd_op = pend_op[t-1];
        cmd_a  = pend_a[t-1];
        cmd_b  = pend_b[t-1];
        exp_cyc.push_back(cyc + LATENCY);
        exp_count = exp_count + CNT_W'(1);
      end
    end
    pend_op.delete();
    pend_a.delete();
    pend_b.delete();
  endtask

  task automatic collect_results();
    int waited;
    int i;
    waited = 0;
    while (got_data.size() < exp_data.size() && waited < TIMEOUT_CYC) begin
      @(posedge clk);
      waited++;
    end
    if (got_data.size() < exp_data.size()) begin
      errors++;
      $display("timeout: only %0d of %0d results arrived within %0d cycles",
               got_data.size(), exp_data.size(), TIMEOUT_CYC);
    end
    // idle cycles would show a stray extra pulse
    repeat (2) @(posedge clk);
    if (got_data.size() > exp_data.size()) begin
      errors++;
      $display("%0d results arrived where %0d commands were sent",
               got_data.size(), exp_data.size());
    end
    for (i = 0; i < got_data.size() && i < exp_data.size(); i++) begin
      check_data("res_data", got_data[i], exp_data[i]);
      check_flag("res_err", got_err[i], exp_err[i]);
      check_latency("res_valid", got_cyc[i], exp_cyc[i]);
    end
    got_data.delete();
    got_err.delete();
    got_cyc.delete();
    exp_data.delete();
    exp_err.delete();
    exp_cyc.delete();
  endtask

  task automatic report_test(input string name);
    $display("%s: %s, %0d errors", name, (errors == test_err_base) ? "pass" : "FAIL",
             errors - test_err_base);
    test_err_base = errors;
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------

  task automatic idle_after_reset();
    int i;
    for (i = 0; i < 10; i++) begin
      @(negedge clk);
      check_flag("res_valid", res_valid, 1'b0);
      check_flag("err_seen", err_seen, 1'b0);
      check_count("res_count", res_count, '0);
    end
    if (got_data.size() != 0) begin
      errors++;
      $display("a result came out although no command was sent");
    end
    report_test("idle after reset");
  endtask

  task automatic basic_alu_ops();
    int op;
    int i;
    for (op = 0; op < 4; op++) begin
      for (i = 0; i < 3; i++) begin
        queue_cmd(OP_W'(op), rand_word(), rand_word());
        send_burst();
        collect_results();
      end
    end
    // wrap-around at both ends
    queue_cmd(ADD, 16'hFFFF, 16'h0002);
    queue_cmd(SUB, 16'h0000, 16'h0001);
    send_burst();
    collect_results();
    report_test("add sub and xor");
  endtask

  task automatic accumulator_sequence();
    expect_cmd(CLR, 16'h1234, 16'h0000, 16'd0, 1'b0);
    expect_cmd(ACC, 16'd5, 16'h0000, 16'd5, 1'b0);
    expect_cmd(ACC, 16'd7, 16'h0000, 16'd12, 1'b0);
    expect_cmd(ACC, 16'hFFFF, 16'h0000, 16'd11, 1'b0);
    send_burst();
    collect_results();
    model_acc = 16'd11;
    report_test("accumulator");
  endtask

  task automatic illegal_opcodes();
    expect_cmd(3'd6, rand_word(), rand_word(), 16'd0, 1'b1);
    queue_cmd(ADD, 16'h0100, 16'h0023);
    expect_cmd(3'd7, 16'd9, rand_word(), 16'd0, 1'b1);
    // 11 plus 3 only if both illegal commands left the accumulator alone
    expect_cmd(ACC, 16'd3, 16'h0000, 16'd14, 1'b0);
    send_burst();
    collect_results();
    model_acc = 16'd14;
    @(negedge clk);
    check_flag("err_seen", err_seen, 1'b1);
    report_test("illegal opcodes");
  endtask

  task automatic back_to_back_burst();
    logic [CNT_W-1:0] count_before;
    int i;
    @(negedge clk);
    count_before = exp_count;
    check_count("res_count", res_count, count_before);
    for (i = 0; i < 20; i++) begin
      queue_cmd(OP_W'(rand_word() % 8), rand_word(), rand_word());
    end
    send_burst();
    collect_results();
    @(negedge clk);
    check_count("res_count", res_count, count_before + CNT_W'(20));
    report_test("back to back");
  endtask

  initial begin
    rst_n          = 1'b0;
    cmd_valid_next = 1'b0;
    cmd_op         = '0;
    cmd_a          = '0;
    cmd_b          = '0;
    lcg_state      = 32'd42896;
    model_acc      = '0;
    exp_count      = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    idle_after_reset();
    basic_alu_ops();
    accumulator_sequence();
    illegal_opcodes();
    back_to_back_burst();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hw/ralu_pkg.sv
hw/ralu_cmd_decode.sv
hw/ralu_delay_valid_next.sv
hw/ralu_execute.sv
hw/ralu_result.sv
hw/ralu_top.sv
bench/ralu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the remote ALU testbench with Verilator.
# Exit status is 0 only when the simulation reports no failure.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=ralu_tb_sim
LOG_FILE=sim.log

# compile RTL and testbench into one executable
verilator --binary --timing --assert -Wno-fatal \
  -f files.f \
  --top-module ralu_tb \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_EXE"
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# run and keep the output for the search below
"./$BUILD_DIR/$SIM_EXE" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints its fail line on any failed check or timeout
if grep -q "Test failed" "$LOG_FILE"; then
  echo "simulation reported a failure, see $LOG_FILE"
  exit 1
fi

echo "simulation passed, log in $LOG_FILE"
exit 0
